// ==== include/video_cfg.svh ====
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

////////////////////////////////////////////////////////////
// 1440x900 HMD mode
////////////////////////////////////////////////////////////
`define HPIXELS_HMD   11'd1440 // Active pixels per line
`define HFRONT_HMD    11'd80   // Front porch
`define HSYNC_W_HMD   11'd152  // Sync pulse width
`define HBACK_HMD     11'd232  // Back porch
`define VLINES_HMD    11'd900  // Active lines per frame
`define VFRONT_HMD    11'd1
`define VSYNC_W_HMD   11'd3
`define VBACK_HMD     11'd28
`define SYNC_POL_HMD  1'b1     // Syncs pulse low
`define BAR_W_HMD     11'd180  // HPIXELS / 8

////////////////////////////////////////////////////////////
// 1024x768 XGA mode
////////////////////////////////////////////////////////////
`define HPIXELS_XGA   11'd1024
`define HFRONT_XGA    11'd24
`define HSYNC_W_XGA   11'd136
`define HBACK_XGA     11'd160
`define VLINES_XGA    11'd768
`define VFRONT_XGA    11'd3
`define VSYNC_W_XGA   11'd6
`define VBACK_XGA     11'd29
`define SYNC_POL_XGA  1'b1
`define BAR_W_XGA     11'd128

////////////////////////////////////////////////////////////
// Pixel clock synthesizer, values stored minus one
////////////////////////////////////////////////////////////
`define PCLK_M_HMD    8'd180   // About 106.5 MHz
`define PCLK_D_HMD    8'd84
`define PCLK_M_XGA    8'd81    // About 65 MHz
`define PCLK_D_XGA    8'd62

// Switch settle time in clk50m_bufg cycles
`define DEBOUNCE_CYCLES 16

// Color bar pattern
`define BAR_LEVEL     8'hC0    // 75 percent amplitude
`define BAR_COUNT     8

`endif

// ==== hw/video_types_pkg.sv ====
`default_nettype none

package video_types_pkg;

	////////////////////////////////////////////////////////////
	// Raster geometry
	////////////////////////////////////////////////////////////
	typedef logic [10:0] video_count_t; // Pixel or line position

	// Selected display format
	typedef logic video_mode_t;

	localparam video_mode_t MODE_HMD = 1'b0; // 1440x900
	localparam video_mode_t MODE_XGA = 1'b1; // 1024x768

	////////////////////////////////////////////////////////////
	// Pixel data
	////////////////////////////////////////////////////////////
	typedef logic [7:0] color_t; // One RGB component

endpackage

`default_nettype wire

// ==== hw/clock_synth_pkg.sv ====
`default_nettype none

package clock_synth_pkg;

	// Multiplier and divider of the pixel clock synthesizer.
	// Both are carried minus one, as the synthesizer expects
	// them on its programming port.
	typedef logic [7:0] synth_factor_t;

endpackage

`default_nettype wire

// ==== hw/mode_switch_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module mode_switch_sync (
	input  wire logic                    clk50m_bufg,
	input  wire logic                    rst_n,
	input  wire logic                    mode_sw,      // Straight from the board switch
	output video_types_pkg::video_mode_t mode_sw_db,
	output logic                         mode_update
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);

	logic             sw_meta;
	logic             sw_sync;
	logic             db_valid;   // A debounced value exists
	logic             sw_differs;
	logic [CNT_W-1:0] settle_cnt;

	// Two flop synchronizer
	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			sw_meta <= 1'b0;
			sw_sync <= 1'b0;
		end else begin
			sw_meta <= mode_sw;
			sw_sync <= sw_meta;
		end
	end

	// Before the first update any settled level counts as new
	assign sw_differs = !db_valid || (sw_sync != mode_sw_db);

	////////////////////////////////////////////////////////////
	// Settle counter
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			settle_cnt  <= '0;
			db_valid    <= 1'b0;
			mode_sw_db  <= video_types_pkg::MODE_HMD;
			mode_update <= 1'b0;
		end else begin
			mode_update <= 1'b0;
			if (!sw_differs) begin
				settle_cnt <= '0;                  // Bounce returned to the old level
			end else if (settle_cnt == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
				settle_cnt  <= '0;
				mode_sw_db  <= sw_sync;            // New level accepted
				db_valid    <= 1'b1;
				mode_update <= 1'b1;
			end else begin
				settle_cnt <= settle_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/video_mode_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module video_mode_regs (
	input  wire logic                          clk50m_bufg,
	input  wire logic                          rst_n,
	input  wire video_types_pkg::video_mode_t  mode_sw_db,
	input  wire logic                          mode_update,
	output video_types_pkg::video_mode_t       mode,
	output logic                               restart,      // Holds the timing generator
	output video_types_pkg::video_count_t      h_blank_start,
	output video_types_pkg::video_count_t      h_sync_start,
	output video_types_pkg::video_count_t      h_sync_end,
	output video_types_pkg::video_count_t      h_total,
	output video_types_pkg::video_count_t      v_blank_start,
	output video_types_pkg::video_count_t      v_sync_start,
	output video_types_pkg::video_count_t      v_sync_end,
	output video_types_pkg::video_count_t      v_total,
	output logic                               sync_pol,
	output video_types_pkg::video_count_t      bar_width,
	output clock_synth_pkg::synth_factor_t     pclk_m,
	output clock_synth_pkg::synth_factor_t     pclk_d,
	output logic                               pclk_go       // Program strobe
);

	video_types_pkg::video_count_t  h_pix, h_fp, h_sw, h_bp;
	video_types_pkg::video_count_t  v_pix, v_fp, v_sw, v_bp;
	video_types_pkg::video_count_t  bar_sel;
	clock_synth_pkg::synth_factor_t m_sel, d_sel;
	logic                           pol_sel;
	logic                           cfg_valid;  // First update seen
	logic                           load_q;
	logic                           load_cfg;

	////////////////////////////////////////////////////////////
	// Mode table
	////////////////////////////////////////////////////////////
	always_comb begin
		case (mode_sw_db)
			video_types_pkg::MODE_XGA: begin
				h_pix   = `HPIXELS_XGA;
				h_fp    = `HFRONT_XGA;
				h_sw    = `HSYNC_W_XGA;
				h_bp    = `HBACK_XGA;
				v_pix   = `VLINES_XGA;
				v_fp    = `VFRONT_XGA;
				v_sw    = `VSYNC_W_XGA;
				v_bp    = `VBACK_XGA;
				pol_sel = `SYNC_POL_XGA;
				bar_sel = `BAR_W_XGA;
				m_sel   = `PCLK_M_XGA;
				d_sel   = `PCLK_D_XGA;
			end
			default: begin
				h_pix   = `HPIXELS_HMD;
				h_fp    = `HFRONT_HMD;
				h_sw    = `HSYNC_W_HMD;
				h_bp    = `HBACK_HMD;
				v_pix   = `VLINES_HMD;
				v_fp    = `VFRONT_HMD;
				v_sw    = `VSYNC_W_HMD;
				v_bp    = `VBACK_HMD;
				pol_sel = `SYNC_POL_HMD;
				bar_sel = `BAR_W_HMD;
				m_sel   = `PCLK_M_HMD;
				d_sel   = `PCLK_D_HMD;
			end
		endcase
	end

	// Follows the switch until the first update, then only on updates
	assign load_cfg = mode_update || !cfg_valid;

	always_ff @(posedge clk50m_bufg) begin
		if (load_cfg) begin
			h_blank_start <= h_pix - 11'd1;
			h_sync_start  <= h_pix - 11'd1 + h_fp;
			h_sync_end    <= h_pix - 11'd1 + h_fp + h_sw;
			h_total       <= h_pix - 11'd1 + h_fp + h_sw + h_bp;
			v_blank_start <= v_pix - 11'd1;
			v_sync_start  <= v_pix - 11'd1 + v_fp;
			v_sync_end    <= v_pix - 11'd1 + v_fp + v_sw;
			v_total       <= v_pix - 11'd1 + v_fp + v_sw + v_bp;
			bar_width     <= bar_sel;
			pclk_m        <= m_sel;
			pclk_d        <= d_sel;
		end
	end

	////////////////////////////////////////////////////////////
	// Update sequencing
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			mode      <= video_types_pkg::MODE_HMD;
			sync_pol  <= `SYNC_POL_HMD;
			cfg_valid <= 1'b0;
			load_q    <= 1'b0;
			pclk_go   <= 1'b0;
			restart   <= 1'b1;
		end else begin
			load_q  <= mode_update;
			pclk_go <= load_q;                  // M and D already stable
			restart <= load_q || !cfg_valid;
			if (mode_update) begin
				mode      <= mode_sw_db;
				sync_pol  <= pol_sel;
				cfg_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing (
	input  wire logic                          clk50m_bufg,
	input  wire logic                          rst_n,
	input  wire logic                          restart,
	input  wire video_types_pkg::video_count_t h_blank_start,
	input  wire video_types_pkg::video_count_t h_sync_start,
	input  wire video_types_pkg::video_count_t h_sync_end,
	input  wire video_types_pkg::video_count_t h_total,
	input  wire video_types_pkg::video_count_t v_blank_start,
	input  wire video_types_pkg::video_count_t v_sync_start,
	input  wire video_types_pkg::video_count_t v_sync_end,
	input  wire video_types_pkg::video_count_t v_total,
	output video_types_pkg::video_count_t      hcount,
	output video_types_pkg::video_count_t      vcount,
	output logic                               hblank,
	output logic                               vblank,
	output logic                               hsync_raw,
	output logic                               vsync_raw
);

	logic h_wrap;
	logic v_wrap;

	assign h_wrap = (hcount == h_total);
	assign v_wrap = (vcount == v_total);

	////////////////////////////////////////////////////////////
	// Pixel and line counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			hcount <= '0;
			vcount <= '0;
		end else if (restart) begin
			hcount <= '0;                        // Parked at the first pixel
			vcount <= '0;
		end else if (h_wrap) begin
			hcount <= '0;
			vcount <= v_wrap ? '0 : vcount + 11'd1;
		end else begin
			hcount <= hcount + 11'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Blanking and sync decode
	////////////////////////////////////////////////////////////
	// Flags describe the count of the previous cycle, so pixel 0 of
	// the first line after restart is not lost
	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			hblank    <= 1'b1;
			vblank    <= 1'b1;
			hsync_raw <= 1'b0;
			vsync_raw <= 1'b0;
		end else if (restart) begin
			hblank    <= 1'b1;                   // No picture while held
			vblank    <= 1'b1;
			hsync_raw <= 1'b0;
			vsync_raw <= 1'b0;
		end else begin
			hblank    <= (hcount > h_blank_start);
			vblank    <= (vcount > v_blank_start);
			hsync_raw <= (hcount > h_sync_start) && (hcount <= h_sync_end);
			vsync_raw <= (vcount > v_sync_start) && (vcount <= v_sync_end);
		end
	end

endmodule

`default_nettype wire

// ==== hw/video_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module video_output_stage (
	input  wire logic                          clk50m_bufg,
	input  wire logic                          rst_n,
	input  wire logic                          hblank,
	input  wire logic                          vblank,
	input  wire logic                          hsync_raw,
	input  wire logic                          vsync_raw,
	input  wire logic                          sync_pol,
	input  wire video_types_pkg::video_count_t bar_width,
	output logic                               hsync,
	output logic                               vsync,
	output logic                               de,
	output video_types_pkg::color_t            red,
	output video_types_pkg::color_t            green,
	output video_types_pkg::color_t            blue
);

	localparam int IDX_W = $clog2(`BAR_COUNT);

	logic                          active;
	logic                          active_s1;
	logic                          hsync_s1, vsync_s1;
	logic                          hsync_s2, vsync_s2;
	logic [IDX_W-1:0]              bar_idx;     // Bar of the current pixel
	logic [IDX_W-1:0]              bar_idx_s1;
	video_types_pkg::video_count_t bar_pix;     // Pixel within the bar

	assign active = !hblank && !vblank;

	////////////////////////////////////////////////////////////
	// Bar position within the line
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			bar_pix <= '0;
			bar_idx <= '0;
		end else if (hblank) begin
			bar_pix <= '0;                       // Rearm for the next line
			bar_idx <= '0;
		end else if (bar_pix == bar_width - 11'd1) begin
			bar_pix <= '0;
			if (bar_idx != IDX_W'(`BAR_COUNT - 1)) begin
				bar_idx <= bar_idx + 1'b1;
			end
		end else begin
			bar_pix <= bar_pix + 11'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Two stage pipeline
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			active_s1  <= 1'b0;
			hsync_s1   <= 1'b0;
			vsync_s1   <= 1'b0;
			bar_idx_s1 <= '0;
			de         <= 1'b0;
			hsync_s2   <= 1'b0;
			vsync_s2   <= 1'b0;
			red        <= '0;
			green      <= '0;
			blue       <= '0;
		end else begin
			active_s1  <= active;
			hsync_s1   <= hsync_raw;
			vsync_s1   <= vsync_raw;
			bar_idx_s1 <= bar_idx;
			de         <= active_s1;
			hsync_s2   <= hsync_s1;
			vsync_s2   <= vsync_s1;
			red        <= (active_s1 && !bar_idx_s1[1]) ? `BAR_LEVEL : '0;
			green      <= (active_s1 && !bar_idx_s1[2]) ? `BAR_LEVEL : '0;
			blue       <= (active_s1 && !bar_idx_s1[0]) ? `BAR_LEVEL : '0;
		end
	end

	// Idle level equals sync_pol
	assign hsync = hsync_s2 ^ sync_pol;
	assign vsync = vsync_s2 ^ sync_pol;

endmodule

`default_nettype wire

// ==== hw/video_pattern_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_pattern_top (
	input  wire logic                      clk50m_bufg,
	input  wire logic                      rst_n,
	input  wire logic                      mode_sw,
	output video_types_pkg::video_mode_t   mode,
	output logic                           hsync,
	output logic                           vsync,
	output logic                           de,
	output video_types_pkg::color_t        red,
	output video_types_pkg::color_t        green,
	output video_types_pkg::color_t        blue,
	output clock_synth_pkg::synth_factor_t pclk_m,
	output clock_synth_pkg::synth_factor_t pclk_d,
	output logic                           pclk_go
);

	video_types_pkg::video_mode_t  mode_sw_db;
	logic                          mode_update;
	logic                          restart;
	video_types_pkg::video_count_t h_blank_start, h_sync_start, h_sync_end, h_total;
	video_types_pkg::video_count_t v_blank_start, v_sync_start, v_sync_end, v_total;
	logic                          sync_pol;
	video_types_pkg::video_count_t bar_width;
	logic                          hblank, vblank;
	logic                          hsync_raw, vsync_raw;

	////////////////////////////////////////////////////////////
	// Mode selection and configuration
	////////////////////////////////////////////////////////////
	mode_switch_sync mode_switch_sync_inst (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.mode_sw     (mode_sw),
		.mode_sw_db  (mode_sw_db),
		.mode_update (mode_update)
	);

	video_mode_regs video_mode_regs_inst (
		.clk50m_bufg   (clk50m_bufg),
		.rst_n         (rst_n),
		.mode_sw_db    (mode_sw_db),
		.mode_update   (mode_update),
		.mode          (mode),
		.restart       (restart),
		.h_blank_start (h_blank_start),
		.h_sync_start  (h_sync_start),
		.h_sync_end    (h_sync_end),
		.h_total       (h_total),
		.v_blank_start (v_blank_start),
		.v_sync_start  (v_sync_start),
		.v_sync_end    (v_sync_end),
		.v_total       (v_total),
		.sync_pol      (sync_pol),
		.bar_width     (bar_width),
		.pclk_m        (pclk_m),
		.pclk_d        (pclk_d),
		.pclk_go       (pclk_go)
	);

	////////////////////////////////////////////////////////////
	// Raster and pattern
	////////////////////////////////////////////////////////////
	video_timing video_timing_inst (
		.clk50m_bufg   (clk50m_bufg),
		.rst_n         (rst_n),
		.restart       (restart),
		.h_blank_start (h_blank_start),
		.h_sync_start  (h_sync_start),
		.h_sync_end    (h_sync_end),
		.h_total       (h_total),
		.v_blank_start (v_blank_start),
		.v_sync_start  (v_sync_start),
		.v_sync_end    (v_sync_end),
		.v_total       (v_total),
		.hcount        (),                   // Bars come from blanking alone
		.vcount        (),
		.hblank        (hblank),
		.vblank        (vblank),
		.hsync_raw     (hsync_raw),
		.vsync_raw     (vsync_raw)
	);

	video_output_stage video_output_stage_inst (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.hblank      (hblank),
		.vblank      (vblank),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw),
		.sync_pol    (sync_pol),
		.bar_width   (bar_width),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.red         (red),
		.green       (green),
		.blue        (blue)
	);

endmodule

`default_nettype wire

// ==== tests/tb_video_pattern_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module tb_video_pattern_top;

	localparam int CYCLE_LIMIT = 6_000_000; // Reset plus two frames per mode, with margin

	logic                           clk50m_bufg = 1'b0;
	logic                           rst_n;
	logic                           mode_sw;
	video_types_pkg::video_mode_t   mode;
	logic                           hsync;
	logic                           vsync;
	logic                           de;
	video_types_pkg::color_t        red;
	video_types_pkg::color_t        green;
	video_types_pkg::color_t        blue;
	clock_synth_pkg::synth_factor_t pclk_m;
	clock_synth_pkg::synth_factor_t pclk_d;
	logic                           pclk_go;

	int          cycle_cnt = 0;
	int unsigned lcg_state;
	logic        armed = 1'b0;
	logic        de_q = 1'b0;
	logic        hsync_q = 1'b1;
	logic        vsync_q = 1'b1;
	logic        de_seen, hs_fall_seen, vs_fall_seen;
	int          go_count = 0;
	int          de_run, hs_low, hs_period, vs_low, line_cnt;
	int          de_checks = 0;
	int          hs_checks = 0;
	int          vs_checked;
	int          exp_hpix, exp_hsw, exp_hper, exp_vsw, exp_vlines, exp_barw;

	video_pattern_top video_pattern_top_inst (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.mode_sw     (mode_sw),
		.mode        (mode),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.pclk_m      (pclk_m),
		.pclk_d      (pclk_d),
		.pclk_go     (pclk_go)
	);

	initial begin
		forever #10 clk50m_bufg = ~clk50m_bufg;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting and helpers
	////////////////////////////////////////////////////////////
	task automatic abort_run(input string line);
		$display("%s", line);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
	endtask

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Bar order white, yellow, cyan, green, magenta, red, blue, black
	function automatic logic [23:0] bar_color(input int pixel, input int width);
		int idx;
		idx = pixel / width;
		case (idx)
			0:       return {8'hC0, 8'hC0, 8'hC0};
			1:       return {8'hC0, 8'hC0, 8'h00};
			2:       return {8'h00, 8'hC0, 8'hC0};
			3:       return {8'h00, 8'hC0, 8'h00};
			4:       return {8'hC0, 8'h00, 8'hC0};
			5:       return {8'hC0, 8'h00, 8'h00};
			6:       return {8'h00, 8'h00, 8'hC0};
			default: return 24'h000000;
		endcase
	endfunction

	task automatic arm_monitor(input int hpix, input int hsw, input int hper,
			input int vsw, input int vlines, input int barw);
		exp_hpix     = hpix;
		exp_hsw      = hsw;
		exp_hper     = hper;
		exp_vsw      = vsw;
		exp_vlines   = vlines;
		exp_barw     = barw;
		de_seen      = 1'b0;
		hs_fall_seen = 1'b0;
		vs_fall_seen = 1'b0;
		line_cnt     = 0;
		vs_checked   = 0;
		armed        = 1'b1;
	endtask

	task automatic wait_for_go(input int n);
		while (go_count < n) @(posedge clk50m_bufg);
		repeat (2) @(posedge clk50m_bufg); // Let the restart reach the outputs
	endtask

	task automatic check_config(input int m, input int d, input logic md, input int gos);
		assert (pclk_m == m)
			else report_mismatch($sformatf("pclk_m %0d, expected %0d", pclk_m, m));
		assert (pclk_d == d)
			else report_mismatch($sformatf("pclk_d %0d, expected %0d", pclk_d, d));
		assert (mode == md)
			else report_mismatch($sformatf("mode %0b, expected %0b", mode, md));
		assert (go_count == gos)
			else report_mismatch($sformatf("%0d pclk_go pulses, expected %0d", go_count, gos));
	endtask

	// Short pulses away from the settled level, each below the debounce length
	task automatic bounce_switch(input logic settled, input int pulses);
		int unsigned width;
		int unsigned gap;
		for (int i = 0; i < pulses; i++) begin
			width = 1 + (lcg_next() >> 8) % (`DEBOUNCE_CYCLES - 1);
			gap   = 1 + (lcg_next() >> 8) % 24;
			mode_sw <= !settled;
			repeat (width) @(posedge clk50m_bufg);
			mode_sw <= settled;
			repeat (gap) @(posedge clk50m_bufg);
		end
		repeat (`DEBOUNCE_CYCLES + 8) @(posedge clk50m_bufg);
	endtask

	////////////////////////////////////////////////////////////
	// Output monitor, sampled on the falling edge
	////////////////////////////////////////////////////////////
	rgb_dark_when_blank: assert property (@(negedge clk50m_bufg)
			!de |-> ({red, green, blue} == 24'h0))
		else report_mismatch("rgb not zero while de is low");

	always @(negedge clk50m_bufg) begin
		if (pclk_go)
			go_count = go_count + 1;
		if (!rst_n)
			assert (!pclk_go) else report_mismatch("pclk_go high during reset");
		if (go_count == 0)
			assert (!de && hsync && vsync)
				else report_mismatch("outputs not idle before update");
		if (armed) begin
			if (de && !de_q) begin
				de_run   = 0;
				de_seen  = 1'b1;
				line_cnt = line_cnt + 1;
			end
			if (de && de_seen) begin
				assert ({red, green, blue} == bar_color(de_run, exp_barw))
					else report_mismatch($sformatf("pixel %0d rgb %h", de_run, {red, green, blue}));
				de_run = de_run + 1;
			end else if (!de && de_q && de_seen) begin
				assert (de_run == exp_hpix)
					else report_mismatch($sformatf("de run %0d, expected %0d", de_run, exp_hpix));
				de_checks = de_checks + 1;
			end
			if (!hsync && hsync_q) begin
				if (hs_fall_seen) begin
					assert (hs_period == exp_hper)
						else report_mismatch($sformatf("line period %0d", hs_period));
					hs_checks = hs_checks + 1;
				end
				hs_period    = 0;
				hs_low       = 0;
				hs_fall_seen = 1'b1;
			end
			if (!hsync)
				hs_low = hs_low + 1;
			else if (!hsync_q && hs_fall_seen)
				assert (hs_low == exp_hsw)
					else report_mismatch($sformatf("hsync low %0d", hs_low));
			hs_period = hs_period + 1;
			if (!vsync && vsync_q) begin
				assert (line_cnt == exp_vlines)
					else report_mismatch($sformatf("%0d active lines in frame", line_cnt));
				line_cnt     = 0;
				vs_low       = 0;
				vs_fall_seen = 1'b1;
			end
			if (!vsync) begin
				vs_low = vs_low + 1;
			end else if (!vsync_q && vs_fall_seen) begin
				assert (vs_low == exp_vsw * exp_hper)
					else report_mismatch($sformatf("vsync low %0d cycles", vs_low));
				vs_checked = vs_checked + 1;
			end
		end
		de_q    = de;
		hsync_q = hsync;
		vsync_q = vsync;
	end

	always @(posedge clk50m_bufg) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		rst_n     = 1'b0;
		mode_sw   = 1'b0;
		lcg_state = 32'd72401;
		repeat (4) @(posedge clk50m_bufg);
		rst_n <= 1'b1;

		// HMD after the first debounced update
		wait_for_go(1);
		check_config(180, 84, 1'b0, 1);
		arm_monitor(1440, 152, 1904, 3, 900, 180);
		while (vs_checked < 2) @(posedge clk50m_bufg);
		check_config(180, 84, 1'b0, 1);

		bounce_switch(1'b0, 8);
		check_config(180, 84, 1'b0, 1);

		// Switch to XGA
		armed = 1'b0;
		mode_sw <= 1'b1;
		wait_for_go(2);
		check_config(81, 62, 1'b1, 2);
		arm_monitor(1024, 136, 1344, 6, 768, 128);
		while (vs_checked < 2) @(posedge clk50m_bufg);

		bounce_switch(1'b1, 8);
		check_config(81, 62, 1'b1, 2);

		if (de_checks > 0 && hs_checks > 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			abort_run("No complete active line or hsync period was measured");
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
hw/video_types_pkg.sv
hw/clock_synth_pkg.sv
hw/mode_switch_sync.sv
hw/video_mode_regs.sv
hw/video_timing.sv
hw/video_output_stage.sv
hw/video_pattern_top.sv
tests/tb_video_pattern_top.sv

// ==== Bender.yml ====
package:
  name: video_pattern

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/video_types_pkg.sv
      - hw/clock_synth_pkg.sv
      - hw/mode_switch_sync.sv
      - hw/video_mode_regs.sv
      - hw/video_timing.sv
      - hw/video_output_stage.sv
      - hw/video_pattern_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_video_pattern_top.sv
